/* design/rmt_pkg.sv */
`default_nettype none

package rmt_pkg;

	// stream beat
	localparam int BEAT_W = 64;
	typedef logic [BEAT_W-1:0] beat_t;

	// header beat layout
	localparam int VLAN_LSB = 52;
	localparam int VLAN_W = 12;
	localparam int DROP_IDX_W = 4;   // low vlan bits that index the drop flags
	localparam int QUEUE_LSB = 50;
	localparam int HOP_LSB = 0;
	localparam int HOP_W = 8;

	// output queues
	localparam int NUM_QUEUES = 4;
	typedef logic [$clog2(NUM_QUEUES)-1:0] queue_idx_t;

	// per-queue packet buffer
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = 4;

endpackage

`default_nettype wire

/* design/pkt_filter.sv */
`timescale 1ns/100ps
`default_nettype none

module pkt_filter
	import rmt_pkg::*;
(
	input  wire                           clk,
	input  wire                           aresetn,
	input  wire [(2**DROP_IDX_W)-1:0]     vlan_drop_flags,
	input  wire beat_t                    in_data,
	input  wire                           in_last,
	input  wire                           in_valid,
	output logic                          in_ready,
	output beat_t                         out_data,
	output logic                          out_last,
	output logic                          out_valid,
	input  wire                           out_ready
);

	logic              is_hdr;     // next accepted beat opens a packet
	logic              drop_lat;   // decision held for the body beats
	logic [VLAN_W-1:0] vlan_id;
	logic              hdr_drop;
	logic              cur_drop;
	logic              in_fire;

	assign vlan_id  = in_data[VLAN_LSB +: VLAN_W];
	assign hdr_drop = vlan_drop_flags[vlan_id[DROP_IDX_W-1:0]];
	assign cur_drop = is_hdr ? hdr_drop : drop_lat;

	// output register empty or draining this cycle
	assign in_ready = !out_valid || out_ready;
	assign in_fire  = in_valid && in_ready;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			is_hdr    <= 1'b1;
			drop_lat  <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			if (in_fire) begin
				is_hdr <= in_last;
				if (is_hdr)
					drop_lat <= hdr_drop;
			end
			if (in_fire && !cur_drop)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	// dropped beats are swallowed here
	always_ff @(posedge clk) begin
		if (in_fire && !cur_drop) begin
			out_data <= in_data;
			out_last <= in_last;
		end
	end

	// stalled beat must not change under the consumer
	a_stall_hold: assert property (@(posedge clk) disable iff (!aresetn)
		out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
		else $error("pkt_filter output changed while stalled");

endmodule

`default_nettype wire

/* design/hop_action.sv */
`timescale 1ns/100ps
`default_nettype none

module hop_action
	import rmt_pkg::*;
(
	input  wire         clk,
	input  wire         aresetn,
	input  wire beat_t  in_data,
	input  wire         in_last,
	input  wire         in_valid,
	output logic        in_ready,
	output beat_t       out_data,
	output logic        out_last,
	output logic        out_valid,
	input  wire         out_ready
);

	logic             is_hdr;
	logic             in_fire;
	logic [HOP_W-1:0] hop;
	beat_t            edit_data;

	assign in_ready = !out_valid || out_ready;
	assign in_fire  = in_valid && in_ready;
	assign hop      = in_data[HOP_LSB +: HOP_W];

	// decrement hop count, stuck at zero
	always_comb begin
		edit_data = in_data;
		if (is_hdr && hop != '0)
			edit_data[HOP_LSB +: HOP_W] = hop - 1'b1;
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			is_hdr    <= 1'b1;
			out_valid <= 1'b0;
		end else begin
			if (in_fire)
				is_hdr <= in_last;
			if (in_fire)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			out_data <= edit_data;
			out_last <= in_last;
		end
	end

	// a held beat is only retired by a handshake
	a_valid_hold: assert property (@(posedge clk) disable iff (!aresetn)
		out_valid && !out_ready |=> out_valid)
		else $error("hop_action dropped out_valid without a transfer");

endmodule

`default_nettype wire

/* design/queue_steer.sv */
`timescale 1ns/100ps
`default_nettype none

module queue_steer
	import rmt_pkg::*;
(
	input  wire                    clk,
	input  wire                    aresetn,
	input  wire beat_t             in_data,
	input  wire                    in_last,
	input  wire                    in_valid,
	output logic                   in_ready,
	input  wire [NUM_QUEUES-1:0]   fifo_full,
	output beat_t                  fifo_wr_data,
	output logic                   fifo_wr_last,
	output logic [NUM_QUEUES-1:0]  fifo_wr_en
);

	logic       is_hdr;
	queue_idx_t q_lat;     // queue of the packet in flight
	queue_idx_t hdr_q;
	queue_idx_t cur_q;
	logic       in_fire;

	assign hdr_q = queue_idx_t'(in_data[QUEUE_LSB +: $bits(queue_idx_t)]);
	assign cur_q = is_hdr ? hdr_q : q_lat;

	assign in_ready     = !fifo_full[cur_q];
	assign in_fire      = in_valid && in_ready;
	assign fifo_wr_data = in_data;
	assign fifo_wr_last = in_last;

	always_comb begin
		for (int i = 0; i < NUM_QUEUES; i++)
			fifo_wr_en[i] = in_fire && (cur_q == queue_idx_t'(i));
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			is_hdr <= 1'b1;
			q_lat  <= '0;
		end else if (in_fire) begin
			is_hdr <= in_last;
			if (is_hdr)
				q_lat <= hdr_q;   // body beats follow their header
		end
	end

	a_one_queue: assert property (@(posedge clk) disable iff (!aresetn)
		$onehot0(fifo_wr_en))
		else $error("queue_steer wrote more than one queue");

endmodule

`default_nettype wire

/* design/queue_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module queue_fifo
	import rmt_pkg::*;
(
	input  wire         clk,
	input  wire         aresetn,
	input  wire beat_t  wr_data,
	input  wire         wr_last,
	input  wire         wr_en,
	output logic        full,
	output beat_t       rd_data,
	output logic        rd_last,
	output logic        empty,
	input  wire         rd_en
);

	beat_t              mem_data [FIFO_DEPTH];
	logic               mem_last [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	logic [FIFO_AW:0]   count;    // one extra bit to tell full from empty

	assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
	assign empty = (count == '0);

	// head entry always on the read side
	assign rd_data = mem_data[rd_ptr];
	assign rd_last = mem_last[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_data[wr_ptr] <= wr_data;
			mem_last[wr_ptr] <= wr_last;
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!aresetn)
		wr_en |-> !full)
		else $error("queue_fifo written while full");

	a_no_underflow: assert property (@(posedge clk) disable iff (!aresetn)
		rd_en |-> !empty)
		else $error("queue_fifo read while empty");

endmodule

`default_nettype wire

/* design/output_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module output_arbiter
	import rmt_pkg::*;
(
	input  wire                    clk,
	input  wire                    aresetn,
	input  wire beat_t             q_data [NUM_QUEUES],
	input  wire [NUM_QUEUES-1:0]   q_last,
	input  wire [NUM_QUEUES-1:0]   q_empty,
	output logic [NUM_QUEUES-1:0]  q_rd_en,
	output beat_t                  out_data,
	output logic                   out_last,
	output logic                   out_valid,
	input  wire                    out_ready
);

	logic       busy;         // a packet holds the output
	queue_idx_t grant;        // owner while busy
	queue_idx_t last_grant;   // round-robin pointer
	queue_idx_t pick_q;
	logic       pick_valid;
	queue_idx_t sel;
	logic       out_fire;

	// first non-empty queue after the last one served
	always_comb begin
		pick_valid = 1'b0;
		pick_q     = last_grant;
		for (int i = 1; i <= NUM_QUEUES; i++) begin
			if (!pick_valid && !q_empty[queue_idx_t'(last_grant + i)]) begin
				pick_valid = 1'b1;
				pick_q     = queue_idx_t'(last_grant + i);
			end
		end
	end

	assign sel       = busy ? grant : pick_q;
	assign out_data  = q_data[sel];
	assign out_last  = q_last[sel];
	assign out_valid = !q_empty[sel];
	assign out_fire  = out_valid && out_ready;

	always_comb begin
		for (int i = 0; i < NUM_QUEUES; i++)
			q_rd_en[i] = out_fire && (sel == queue_idx_t'(i));
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			busy       <= 1'b0;
			grant      <= '0;
			last_grant <= queue_idx_t'(NUM_QUEUES-1);   // queue 0 goes first
		end else if (out_fire && out_last) begin
			busy       <= 1'b0;
			last_grant <= sel;
		end else if (!busy && pick_valid) begin
			// lock on first offer, so a stalled beat cannot be swapped
			busy  <= 1'b1;
			grant <= pick_q;
		end
	end

	// whole packets only, no interleaving
	a_grant_lock: assert property (@(posedge clk) disable iff (!aresetn)
		busy && !(out_fire && out_last) |=> busy && $stable(grant))
		else $error("output_arbiter moved the grant inside a packet");

endmodule

`default_nettype wire

/* design/rmt_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rmt_top
	import rmt_pkg::*;
(
	input  wire                           clk,
	input  wire                           aresetn,
	input  wire [(2**DROP_IDX_W)-1:0]     vlan_drop_flags,
	input  wire beat_t                    in_data,
	input  wire                           in_last,
	input  wire                           in_valid,
	output logic                          in_ready,
	output beat_t                         out_data,
	output logic                          out_last,
	output logic                          out_valid,
	input  wire                           out_ready
);

	// filter to action stage
	beat_t filt_data;
	logic  filt_last;
	logic  filt_valid;
	logic  filt_ready;

	// action stage to steering
	beat_t hop_data;
	logic  hop_last;
	logic  hop_valid;
	logic  hop_ready;

	// steering to the queue fifos, shared write bus
	beat_t                 wr_data;
	logic                  wr_last;
	logic [NUM_QUEUES-1:0] wr_en;
	logic [NUM_QUEUES-1:0] q_full;

	// fifo read side to the arbiter
	beat_t                 q_data [NUM_QUEUES];
	logic [NUM_QUEUES-1:0] q_last;
	logic [NUM_QUEUES-1:0] q_empty;
	logic [NUM_QUEUES-1:0] q_rd_en;

	pkt_filter u_pkt_filter (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.in_data         (in_data),
		.in_last         (in_last),
		.in_valid        (in_valid),
		.in_ready        (in_ready),
		.out_data        (filt_data),
		.out_last        (filt_last),
		.out_valid       (filt_valid),
		.out_ready       (filt_ready)
	);

	hop_action u_hop_action (
		.clk       (clk),
		.aresetn   (aresetn),
		.in_data   (filt_data),
		.in_last   (filt_last),
		.in_valid  (filt_valid),
		.in_ready  (filt_ready),
		.out_data  (hop_data),
		.out_last  (hop_last),
		.out_valid (hop_valid),
		.out_ready (hop_ready)
	);

	queue_steer u_queue_steer (
		.clk          (clk),
		.aresetn      (aresetn),
		.in_data      (hop_data),
		.in_last      (hop_last),
		.in_valid     (hop_valid),
		.in_ready     (hop_ready),
		.fifo_full    (q_full),
		.fifo_wr_data (wr_data),
		.fifo_wr_last (wr_last),
		.fifo_wr_en   (wr_en)
	);

	for (genvar i = 0; i < NUM_QUEUES; i++) begin : g_queue
		queue_fifo u_queue_fifo (
			.clk     (clk),
			.aresetn (aresetn),
			.wr_data (wr_data),
			.wr_last (wr_last),
			.wr_en   (wr_en[i]),
			.full    (q_full[i]),
			.rd_data (q_data[i]),
			.rd_last (q_last[i]),
			.empty   (q_empty[i]),
			.rd_en   (q_rd_en[i])
		);
	end

	output_arbiter u_output_arbiter (
		.clk       (clk),
		.aresetn   (aresetn),
		.q_data    (q_data),
		.q_last    (q_last),
		.q_empty   (q_empty),
		.q_rd_en   (q_rd_en),
		.out_data  (out_data),
		.out_last  (out_last),
		.out_valid (out_valid),
		.out_ready (out_ready)
	);

endmodule

`default_nettype wire

/* bench/clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
	output logic clk,
	output logic aresetn
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;   // 10 ns period
	end

	initial begin
		aresetn = 1'b0;
		repeat (4) @(posedge clk);
		#1 aresetn = 1'b1;   // release away from the edge
	end

endmodule

`default_nettype wire

/* bench/tb_rmt.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rmt
	import rmt_pkg::*;
();

	localparam int NUM_PKTS        = 200;
	localparam int HANDSHAKE_LIMIT = 2000;
	localparam int DRAIN_LIMIT     = 20000;
	localparam int RESET_LIMIT     = 20;

	logic                       clk;
	logic                       aresetn;
	logic [(2**DROP_IDX_W)-1:0] vlan_drop_flags;
	beat_t                      in_data;
	logic                       in_last;
	logic                       in_valid;
	logic                       in_ready;
	beat_t                      out_data;
	logic                       out_last;
	logic                       out_valid;
	logic                       out_ready;

	logic [31:0] lfsr_state = 32'h8e67_dd57;

	// expected packets, one beat stream per queue number
	beat_t exp_data [NUM_QUEUES][$];
	logic  exp_last [NUM_QUEUES][$];
	int    pending_beats = 0;
	int    in_stall_cycles = 0;
	int    kept_pkts = 0;
	int    dropped_pkts = 0;

	clk_gen u_clk_gen (
		.clk     (clk),
		.aresetn (aresetn)
	);

	rmt_top u_rmt_top (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.in_data         (in_data),
		.in_last         (in_last),
		.in_valid        (in_valid),
		.in_ready        (in_ready),
		.out_data        (out_data),
		.out_last        (out_last),
		.out_valid       (out_valid),
		.out_ready       (out_ready)
	);

	// galois lfsr, one step per bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (b)
			lfsr_state = lfsr_state ^ 32'hD000_0001;
		return b;
	endfunction

	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[62:0], lfsr_bit()};
		return v;
	endfunction

	task automatic abort_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic report_timeout(input string what);
		$display("ERROR: timed out %s", what);
		abort_run();
	endtask

	task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h, expected %h", name, got, exp);
			abort_run();
		end
	endtask

	// returns 1 ns after the first clock edge out of reset
	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		@(posedge clk);
		while (aresetn !== 1'b1) begin
			if (cycles > RESET_LIMIT)
				report_timeout("waiting for reset release");
			cycles++;
			@(posedge clk);
		end
		#1;
	endtask

	task automatic send_beat(input beat_t data, input logic last);
		int waited;
		waited = 0;
		in_data  = data;
		in_last  = last;
		in_valid = 1'b1;
		@(negedge clk);
		while (!in_ready) begin
			if (waited > HANDSHAKE_LIMIT)
				report_timeout("waiting for in_ready");
			waited++;
			in_stall_cycles++;
			@(negedge clk);
		end
		@(posedge clk);   // beat taken here
		#1;
	endtask

	task automatic send_packet();
		beat_t            pkt [4];
		int               len;
		logic [VLAN_W-1:0] vlan;
		queue_idx_t       q;
		logic [HOP_W-1:0] hop;
		beat_t            hdr_exp;
		len = 1 + int'(rand_bits(2));
		for (int i = 0; i < len; i++)
			pkt[i] = rand_bits(BEAT_W);
		if (rand_bits(3) == 0)
			pkt[0][HOP_LSB +: HOP_W] = '0;   // exercise the zero floor
		vlan = pkt[0][VLAN_LSB +: VLAN_W];
		q    = pkt[0][QUEUE_LSB +: $bits(queue_idx_t)];
		hop  = pkt[0][HOP_LSB +: HOP_W];
		if (vlan_drop_flags[vlan[DROP_IDX_W-1:0]]) begin
			dropped_pkts++;
		end else begin
			kept_pkts++;
			hdr_exp = pkt[0];
			if (hop != 0)
				hdr_exp[HOP_LSB +: HOP_W] = hop - 8'd1;
			for (int i = 0; i < len; i++) begin
				exp_data[q].push_back(i == 0 ? hdr_exp : pkt[i]);
				exp_last[q].push_back(i == len - 1);
				pending_beats++;
			end
		end
		for (int i = 0; i < len; i++)
			send_beat(pkt[i], i == len - 1);
	endtask

	initial begin : stimulus
		int idle;
		int cycles;
		in_data         = '0;
		in_last         = 1'b0;
		in_valid        = 1'b0;
		out_ready       = 1'b0;
		vlan_drop_flags = '0;
		wait_reset_release();
		vlan_drop_flags = rand_bits(16) & rand_bits(16);   // about a quarter dropped
		for (int p = 0; p < NUM_PKTS; p++) begin
			send_packet();
			in_valid = 1'b0;
			idle = int'(rand_bits(2));
			repeat (idle) begin
				@(posedge clk);
				#1;
			end
		end
		in_valid = 1'b0;
		cycles = 0;
		while (pending_beats != 0) begin
			if (cycles > DRAIN_LIMIT)
				report_timeout("draining the queues");
			cycles++;
			@(posedge clk);
		end
		repeat (50) @(negedge clk);
		check_eq("out_valid", out_valid, 1'b0);   // nothing left over
		check_eq("in_ready_stalled", in_stall_cycles > 0, 1'b1);
		$display("kept %0d packets, dropped %0d", kept_pkts, dropped_pkts);
		$display("PASS: all tests");
		$finish;
	end

	// random ready with long stalls that back the fifos up
	initial begin : ready_gen
		int n;
		wait_reset_release();
		forever begin
			n = 32 + int'(rand_bits(5));
			repeat (n) begin
				out_ready = (rand_bits(2) != 0);
				@(posedge clk);
				#1;
			end
			out_ready = 1'b0;
			n = 300 + int'(rand_bits(7));
			repeat (n) begin
				@(posedge clk);
				#1;
			end
		end
	end

	initial begin : monitor
		queue_idx_t cur_q;
		logic       in_pkt;
		logic       prev_stall;
		beat_t      prev_data;
		logic       prev_last;
		int         post_rst;
		cur_q      = '0;
		in_pkt     = 1'b0;
		prev_stall = 1'b0;
		prev_data  = '0;
		prev_last  = 1'b0;
		post_rst   = 0;
		forever begin
			@(negedge clk);
			if (aresetn !== 1'b1) begin
				check_eq("out_valid", out_valid, 1'b0);
				post_rst   = 0;
				prev_stall = 1'b0;
			end else begin
				if (post_rst < 2) begin
					check_eq("out_valid", out_valid, 1'b0);
					post_rst++;
				end
				if (prev_stall) begin
					check_eq("out_valid", out_valid, 1'b1);
					check_eq("out_data", out_data, prev_data);
					check_eq("out_last", out_last, prev_last);
				end
				if (out_valid && out_ready) begin
					if (!in_pkt)
						cur_q = out_data[QUEUE_LSB +: $bits(queue_idx_t)];
					if (exp_data[cur_q].size() == 0) begin
						$display("ERROR: output beat on queue %0d with no packet expected", cur_q);
						abort_run();
					end
					check_eq("out_data", out_data, exp_data[cur_q].pop_front());
					check_eq("out_last", out_last, exp_last[cur_q].pop_front());
					pending_beats--;
					in_pkt = !out_last;
				end
				prev_stall = out_valid && !out_ready;
				prev_data  = out_data;
				prev_last  = out_last;
			end
		end
	end

endmodule

`default_nettype wire

/* src.f */
design/rmt_pkg.sv
design/pkt_filter.sv
design/hop_action.sv
design/queue_steer.sv
design/queue_fifo.sv
design/output_arbiter.sv
design/rmt_top.sv
bench/clk_gen.sv
bench/tb_rmt.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_rmt -o tb_rmt &&
./obj_dir/tb_rmt || exit 1
